// ==== hdl/periph_pkg.sv ====
// Peripheral block package with register map, bus word types and interrupt sources
package periph_pkg;

	// Bus and port types --------------------
	typedef logic [15:0] data_t;        // Register bus data word
	typedef logic [2:0]  reg_addr_t;    // Register index
	typedef logic [7:0]  byte_t;        // Serial data byte
	typedef logic [2:0]  irq_src_t;     // Bit 0 rx valid, 1 tx ready, 2 PWM period
	typedef logic [1:0]  irq_vec_t;     // Number of the winning source
	typedef logic [6:0]  gpi_t;         // General-purpose input port

	localparam int PWM_BITS = 8;        // PWM counter width
	typedef logic [PWM_BITS-1:0] duty_t;

	// Register indices --------------------
	localparam reg_addr_t REG_IRQEN = 3'd0;
	localparam reg_addr_t REG_FLAGS = 3'd1;     // Read-only status
	localparam reg_addr_t REG_UART  = 3'd2;
	localparam reg_addr_t REG_GPIO  = 3'd4;
	localparam reg_addr_t REG_SDTY  = 3'd6;     // Screen dirty clear

	// FLAGS word bit positions
	localparam int FLAG_RX_VALID  = 0;
	localparam int FLAG_TX_READY  = 1;
	localparam int FLAG_OVERRUN   = 2;
	localparam int FLAG_FRAME_ERR = 3;
	localparam int FLAG_PWM_IRQ   = 4;
	localparam int FLAG_CTRL_C    = 5;
	localparam int FLAG_SDTY      = 6;

	localparam byte_t CTRL_C_CODE = 8'd3;   // ASCII ETX

endpackage

// ==== hdl/uart_pkg.sv ====
// UART package with the 8N1 frame format and baud timing constants
package uart_pkg;

	// Baud timing --------------------
	localparam int BAUD_DIV = 8;        // Clock cycles per bit

	// Frame format
	// One start bit, eight data bits and one stop bit.
	// The receiver shift register and the transmit bit
	// counter are both sized from these values.
	localparam int FRAME_BITS = 10;     // Start + data + stop
	localparam int DATA_BITS  = 8;      // Payload bits, LSB first

	// Line level between frames and of the stop bit
	localparam logic IDLE_LEVEL = 1'b1;

endpackage

// ==== hdl/uart_if.sv ====
// UART bus interface between the register block and the transmit and receive halves
`timescale 1ns/1ps

interface uart_if;
	import periph_pkg::*;

	// Register block to UART
	byte_t tx_data;         // Byte to send
	logic  tx_wr;           // Start pulse
	logic  rx_rd;           // Clears rx flags

	// UART to register block
	logic  tx_ready;        // Transmitter idle
	byte_t rx_data;         // Last received byte
	logic  rx_valid;        // Byte waiting
	logic  rx_overrun;      // Second byte before read
	logic  rx_frame_err;    // Stop bit of buffered byte low

	modport regs (
		output tx_data, tx_wr, rx_rd,
		input  tx_ready, rx_data, rx_valid, rx_overrun, rx_frame_err
	);

	modport tx (input tx_data, tx_wr, output tx_ready);

	modport rx (input rx_rd, output rx_data, rx_valid, rx_overrun, rx_frame_err);

endinterface

// ==== hdl/baud_counter.sv ====
// Baud counter dividing clk into bit periods with restart, bit-end and mid-bit outputs
`timescale 1ns/1ps

module baud_counter #(
	parameter int DIVIDER = uart_pkg::BAUD_DIV      // Cycles per bit, 2 or more
) (
	input  logic clk,
	input  logic reset,
	input  logic restart,       // Forces count to zero
	output logic bit_end,       // Last count of the bit
	output logic mid_bit        // Sample point
);

	localparam int CNT_BITS = (DIVIDER > 2) ? $clog2(DIVIDER) : 1;

	logic [CNT_BITS-1:0] count;

	// Divider --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (restart || bit_end) begin
			count <= '0;                // Wrap or resync
		end else begin
			count <= count + 1'b1;
		end
	end

	assign bit_end = (count == CNT_BITS'(DIVIDER - 1));
	assign mid_bit = (count == CNT_BITS'(DIVIDER / 2 - 1));    // Half way into the bit

endmodule

// ==== hdl/uart_tx.sv ====
// UART transmitter sending start, eight data and one stop bit per written byte
`timescale 1ns/1ps

module uart_tx (
	input  logic clk,
	input  logic reset,
	uart_if.tx   uart,
	output logic txd
);
	import uart_pkg::*;

	localparam int CNT_BITS = $clog2(FRAME_BITS + 1);

	logic                  bit_end;     // End of current bit
	logic [DATA_BITS:0]    tx_shift;    // Data plus start bit
	logic [CNT_BITS-1:0]   bit_cnt;     // Bits left in frame
	logic                  busy;

	// Bit timing restarts with each write
	baud_counter baud_i (
		.clk     (clk),
		.reset   (reset),
		.restart (uart.tx_wr),
		.bit_end (bit_end),
		.mid_bit ()
	);

	// Shift register --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_shift <= {(DATA_BITS + 1){IDLE_LEVEL}};
		end else if (uart.tx_wr) begin
			tx_shift <= {uart.tx_data, ~IDLE_LEVEL};        // Start bit at LSB
		end else if (bit_end) begin
			tx_shift <= {IDLE_LEVEL, tx_shift[DATA_BITS:1]}; // Stop level fills from top
		end
	end

	// Frame bit counter
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bit_cnt <= '0;
		end else if (uart.tx_wr) begin
			bit_cnt <= CNT_BITS'(FRAME_BITS);
		end else if (busy && bit_end) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	assign busy          = |bit_cnt;
	assign uart.tx_ready = ~busy;
	assign txd           = tx_shift[0];     // LSB first on the line

endmodule

// ==== hdl/uart_rx.sv ====
// UART receiver with input synchronizer, mid-bit sampling, byte buffer and status flags
`timescale 1ns/1ps

module uart_rx (
	input  logic clk,
	input  logic reset,
	uart_if.rx   uart,
	input  logic rxd
);
	import periph_pkg::*;
	import uart_pkg::*;

	logic [1:0]            rxd_sync;    // Two-flop synchronizer
	logic                  rxd_edge;    // Any line transition
	logic                  sample;      // Mid-bit strobe
	logic [FRAME_BITS-1:0] rx_shift;    // Start bit walks to bit 0
	logic                  frame_done;
	byte_t                 rx_buf;      // Received data
	logic                  rx_stop;     // Stop bit of buffered byte
	logic [1:0]            rx_val;      // Overrun above valid

	// Synchronizer --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxd_sync <= {2{IDLE_LEVEL}};
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
		end
	end

	assign rxd_edge = rxd_sync[1] ^ rxd_sync[0];

	// Bit clock realigns on every edge
	baud_counter baud_i (
		.clk     (clk),
		.reset   (reset),
		.restart (rxd_edge),
		.bit_end (),
		.mid_bit (sample)
	);

	// Sampling shift register --------------------
	// Armed with all ones. A low start bit reaching bit 0 means
	// data and stop sit above it and the frame is complete.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_shift <= '1;
		end else if (frame_done) begin
			rx_shift <= '1;                 // Re-arm for next frame
		end else if (sample) begin
			rx_shift <= {rxd_sync[1], rx_shift[FRAME_BITS-1:1]};
		end
	end

	assign frame_done = ~rx_shift[0];

	always_ff @(posedge clk) begin
		if (frame_done) rx_buf <= rx_shift[DATA_BITS:1];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_stop <= IDLE_LEVEL;          // No frame error after reset
			rx_val  <= 2'b00;
		end else if (frame_done) begin
			rx_stop <= rx_shift[FRAME_BITS-1];
			rx_val  <= {rx_val[0], 1'b1};   // Valid, overrun if already valid
		end else if (uart.rx_rd) begin
			rx_val  <= 2'b00;
		end
	end

	assign uart.rx_data      = rx_buf;
	assign uart.rx_valid     = rx_val[0];
	assign uart.rx_overrun   = rx_val[1];
	assign uart.rx_frame_err = (rx_stop != IDLE_LEVEL);    // Stop bit low

endmodule

// ==== hdl/pwm_gen.sv ====
// PWM generator with free-running counter, double-buffered duty and period interrupt
`timescale 1ns/1ps

module pwm_gen (
	input  logic               clk,
	input  logic               reset,
	input  periph_pkg::duty_t  duty,        // New duty value
	input  logic               duty_wr,     // Load hold and clear irq
	output logic               pwm_out,
	output logic               pwm_irq      // Period start flag
);
	import periph_pkg::*;

	duty_t pwm_hold;        // Written by the bus
	duty_t pwm_buf;         // Compared value for this period
	duty_t pwm_cnt;
	logic  cnt_wrap;        // Terminal count 2^n - 2
	logic  cnt_zero;

	assign cnt_wrap = (pwm_cnt == duty_t'((1 << PWM_BITS) - 2));
	assign cnt_zero = (pwm_cnt == '0);

	// Counter and output --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwm_hold <= '0;
			pwm_buf  <= '0;
			pwm_cnt  <= '0;
			pwm_out  <= 1'b0;
			pwm_irq  <= 1'b0;
		end else begin
			if (duty_wr) pwm_hold <= duty;
			if (cnt_wrap) pwm_buf <= pwm_hold;      // Takes effect next period
			pwm_cnt <= cnt_wrap ? '0 : pwm_cnt + 1'b1;
			if (pwm_cnt == pwm_buf) pwm_out <= 1'b0;    // Zero duty wins at count 0
			else if (cnt_zero) pwm_out <= 1'b1;
			if (cnt_zero) pwm_irq <= 1'b1;
			else if (duty_wr) pwm_irq <= 1'b0;
		end
	end

endmodule

// ==== hdl/io_regs.sv ====
// Register block decoding the bus, holding control registers and prioritizing interrupts
`timescale 1ns/1ps

module io_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  periph_pkg::reg_addr_t  addr,
	input  periph_pkg::data_t      wdata,
	input  logic                   wr,
	input  logic                   rd,
	output periph_pkg::data_t      rdata,
	output logic                   stall,
	output logic                   irq,
	output periph_pkg::irq_vec_t   irq_vec,
	input  periph_pkg::gpi_t       gpi,
	output logic                   gpo,
	uart_if.regs                   uart,
	output periph_pkg::duty_t      duty,
	output logic                   duty_wr,
	input  logic                   pwm_irq
);
	import periph_pkg::*;

	logic     sel_flags;
	logic     sel_uart;
	logic     wr_ok;        // Write not stalled
	logic     rd_ok;
	irq_src_t irq_en;       // IRQEN register
	irq_src_t irq_act;      // Enabled active sources
	logic     sdty;         // Screen dirty
	logic     ctrl_c;
	data_t    flags;

	// Decode and stall --------------------
	assign sel_flags = (addr == REG_FLAGS);
	assign sel_uart  = (addr == REG_UART);
	assign stall     = sel_uart && ((rd && !uart.rx_valid) || (wr && !uart.tx_ready));
	assign wr_ok     = wr && !stall;
	assign rd_ok     = rd && !stall;

	assign uart.tx_data = wdata[7:0];
	assign uart.tx_wr   = wr_ok && sel_uart;
	assign uart.rx_rd   = rd_ok && sel_uart;    // Clears valid and overrun
	assign duty         = wdata[PWM_BITS-1:0];
	assign duty_wr      = wr_ok && sel_flags;   // FLAGS write reloads PWM

	// Control registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irq_en <= '0;
			gpo    <= 1'b0;
			sdty   <= 1'b0;
		end else if (wr_ok) begin
			if (addr == REG_IRQEN) irq_en <= wdata[2:0];
			if (addr == REG_GPIO) gpo <= wdata[0];
			if (sel_uart) sdty <= 1'b1;     // Any sent char dirties screen
			else if (addr == REG_SDTY) sdty <= 1'b0;
		end
	end

	// Status word --------------------
	assign ctrl_c = uart.rx_valid && (uart.rx_data == CTRL_C_CODE);

	always_comb begin
		flags                 = '0;
		flags[FLAG_RX_VALID]  = uart.rx_valid;
		flags[FLAG_TX_READY]  = uart.tx_ready;
		flags[FLAG_OVERRUN]   = uart.rx_overrun;
		flags[FLAG_FRAME_ERR] = uart.rx_frame_err;
		flags[FLAG_PWM_IRQ]   = pwm_irq;
		flags[FLAG_CTRL_C]    = ctrl_c;
		flags[FLAG_SDTY]      = sdty;
	end

	// Read mux
	always_comb begin
		case (addr)
			REG_IRQEN: rdata = data_t'(irq_en);
			REG_FLAGS: rdata = flags;
			REG_UART:  rdata = data_t'(uart.rx_data);
			REG_GPIO:  rdata = data_t'({gpi, gpo});     // Inputs above gpo
			default:   rdata = '0;
		endcase
	end

	// Interrupts --------------------
	assign irq_act = irq_en & {pwm_irq, uart.tx_ready, uart.rx_valid};
	assign irq     = |irq_act;

	always_comb begin
		if (irq_act[0]) irq_vec = 2'd0;     // Lowest number wins
		else if (irq_act[1]) irq_vec = 2'd1;
		else if (irq_act[2]) irq_vec = 2'd2;
		else irq_vec = 2'd0;
	end

endmodule

// ==== hdl/periph_top.sv ====
// Peripheral subsystem top joining register block, UART halves and PWM to plain ports
`timescale 1ns/1ps

module periph_top (
	input  logic                   clk,
	input  logic                   reset,
	input  periph_pkg::reg_addr_t  addr,
	input  periph_pkg::data_t      wdata,
	input  logic                   wr,
	input  logic                   rd,
	output periph_pkg::data_t      rdata,
	output logic                   stall,       // Repeat access while high
	output logic                   irq,
	output periph_pkg::irq_vec_t   irq_vec,
	input  periph_pkg::gpi_t       gpi,
	output logic                   gpo,
	input  logic                   rxd,
	output logic                   txd,
	output logic                   pwm_out
);
	import periph_pkg::*;

	duty_t duty;            // PWM hold value from bus
	logic  duty_wr;
	logic  pwm_irq;

	// Register block to UART
	uart_if uart_bus ();

	io_regs regs_i (
		.clk     (clk),
		.reset   (reset),
		.addr    (addr),
		.wdata   (wdata),
		.wr      (wr),
		.rd      (rd),
		.rdata   (rdata),
		.stall   (stall),
		.irq     (irq),
		.irq_vec (irq_vec),
		.gpi     (gpi),
		.gpo     (gpo),
		.uart    (uart_bus),
		.duty    (duty),
		.duty_wr (duty_wr),
		.pwm_irq (pwm_irq)
	);

	uart_tx tx_i (.clk(clk), .reset(reset), .uart(uart_bus), .txd(txd));

	uart_rx rx_i (.clk(clk), .reset(reset), .uart(uart_bus), .rxd(rxd));

	pwm_gen pwm_i (
		.clk     (clk),
		.reset   (reset),
		.duty    (duty),
		.duty_wr (duty_wr),
		.pwm_out (pwm_out),
		.pwm_irq (pwm_irq)
	);

endmodule

// ==== sim/tb_clock.sv ====
// Testbench clock and reset generator for the peripheral block
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 4,     // Clock period
	parameter int RESET_CYCLES = 5      // Reset length in clocks
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;                // Released off the edge
	end

endmodule

// ==== sim/periph_checker.sv ====
// Protocol checker bound to the peripheral top level with concurrent assertions
`timescale 1ns/1ps

module periph_checker (
	input logic                 clk,
	input logic                 reset,
	input logic                 wr,
	input logic                 rd,
	input logic                 stall,
	input logic                 txd,
	input logic                 tx_ready,
	input logic                 irq,
	input periph_pkg::irq_src_t irq_en,     // IRQEN register
	input periph_pkg::irq_src_t irq_src     // Raw sources
);

	// Idle transmitter holds the line at stop level
	tx_idle_high: assert property (@(posedge clk) disable iff (reset) tx_ready |-> txd)
		else $error("txd low while transmitter idle");

	// Stall only answers an access
	stall_on_access: assert property (@(posedge clk) disable iff (reset) stall |-> (rd || wr))
		else $error("stall high without rd or wr");

	// No enabled source may hide behind a low irq
	irq_complete: assert property (@(posedge clk) disable iff (reset)
		!irq |-> ((irq_en & irq_src) == '0))
		else $error("irq low with an enabled active source");

endmodule

bind periph_top periph_checker checker_i (
	.clk      (clk),
	.reset    (reset),
	.wr       (wr),
	.rd       (rd),
	.stall    (stall),
	.txd      (txd),
	.tx_ready (uart_bus.tx_ready),
	.irq      (irq),
	.irq_en   (regs_i.irq_en),
	.irq_src  ({pwm_irq, uart_bus.tx_ready, uart_bus.rx_valid})
);

// ==== sim/tb_periph.sv ====
// Testbench for the peripheral block with LFSR stimulus, reference model and watchdog
`timescale 1ns/1ps

module tb_periph;
	import periph_pkg::*;
	import uart_pkg::*;

	localparam int FRAME_CYCLES = FRAME_BITS * BAUD_DIV;
	localparam int PWM_PERIOD   = (1 << PWM_BITS) - 1;    // Counts 0 to 2^n - 2
	localparam int TX_N  = 4;
	localparam int RX_N  = 4;
	localparam int PWM_N = 3;
	localparam int IRQ_N = 8;
	localparam int WATCHDOG_CYCLES = FRAME_CYCLES * 2 * (TX_N + RX_N + 5 + 1)
		+ PWM_PERIOD * (3 * PWM_N + 1) + 2000;   // Frames, PWM periods, margin

	logic clk, reset;
	reg_addr_t addr;
	data_t wdata, rdata;
	logic wr, rd, stall, irq, gpo, rxd, txd, pwm_out;
	irq_vec_t irq_vec;
	gpi_t gpi;

	logic [31:0] lfsr = 32'd86343;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_base = 0;

	tb_clock clock_i (.clk(clk), .reset(reset));

	periph_top periph_top_i (.*);

	always @(posedge clk) cycle <= cycle + 1;

	// Helpers --------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);     // One step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Line level of frame bit i
	function automatic logic frame_bit(input byte_t b, input logic stop, input int i);
		if (i == 0) return 1'b0;
		if (i <= DATA_BITS) return b[i-1];
		return stop;
	endfunction

	function automatic irq_vec_t lowest_source(input irq_src_t act);
		irq_vec_t v;
		v = '0;
		for (int i = 2; i >= 0; i--) begin
			if (act[i]) v = irq_vec_t'(i);
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %-10s done with %0d errors", name, errors - test_base);
		test_base = errors;
		tests++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;                         // Drive phase
		end
	endtask

	task automatic bus_write(input reg_addr_t a, input data_t d, output logic stalled);
		addr = a;
		wdata = d;
		wr = 1'b1;
		#1;
		stalled = stall;
		wait_cycles(1);
		wr = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t a, output data_t value, output logic stalled);
		addr = a;
		rd = 1'b1;
		#1;
		value = rdata;
		stalled = stall;
		wait_cycles(1);
		rd = 1'b0;
	endtask

	// Look at a register without a read strobe
	task automatic peek_reg(input reg_addr_t a, output data_t value);
		addr = a;
		#1;
		value = rdata;
		wait_cycles(1);
	endtask

	task automatic wait_flag(input int pos, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		addr = REG_FLAGS;
		do begin
			wait_cycles(1);
			n++;
		end while (rdata[pos] !== level && n < limit);
		if (rdata[pos] !== level) begin
			errors++;
			$display("Timeout after %0d cycles waiting for %s", limit, what);
		end
	endtask

	task automatic send_frame(input byte_t b, input logic stop);
		for (int i = 0; i < FRAME_BITS; i++) begin
			rxd = frame_bit(b, stop, i);
			wait_cycles(BAUD_DIV);
		end
		rxd = IDLE_LEVEL;
	endtask

	// Transmit --------------------
	task automatic transmit_frames();
		byte_t b;
		logic stalled;
		int start;
		for (int k = 0; k < TX_N; k++) begin
			b = byte_t'(rand_bits(8));
			bus_write(REG_UART, data_t'(b), stalled);
			start = cycle;              // Write edge
			check("stall on idle tx write", stalled, 1'b0);
			bus_write(REG_UART, data_t'(~b), stalled);     // Busy, must be dropped
			check("stall on busy tx write", stalled, 1'b1);
			wait_cycles(BAUD_DIV / 2 - 1);                  // To middle of start bit
			for (int i = 0; i < FRAME_BITS; i++) begin
				check("txd", txd, frame_bit(b, 1'b1, i));
				if (i < FRAME_BITS - 1) wait_cycles(BAUD_DIV);
			end
			wait_flag(FLAG_TX_READY, 1'b1, FRAME_CYCLES, "tx ready");
			check("tx ready cycles", cycle - start, FRAME_CYCLES);
		end
		finish_test("transmit");
	endtask

	// Receive --------------------
	task automatic receive_frames();
		byte_t b;
		data_t v;
		logic stalled;
		bus_read(REG_UART, v, stalled);
		check("stall on empty rx read", stalled, 1'b1);
		for (int k = 0; k < RX_N; k++) begin
			b = byte_t'(rand_bits(8));
			send_frame(b, 1'b1);
			wait_flag(FLAG_RX_VALID, 1'b1, FRAME_CYCLES, "rx valid");
			bus_read(REG_UART, v, stalled);
			check("stall on rx read", stalled, 1'b0);
			check("rx data", v, data_t'(b));
			peek_reg(REG_FLAGS, v);
			check("rx valid after read", v[FLAG_RX_VALID], 1'b0);
		end
		finish_test("receive");
	endtask

	task automatic receive_errors();
		byte_t b1, b2;
		data_t v;
		logic stalled;
		b1 = byte_t'(rand_bits(8));
		b2 = byte_t'(rand_bits(8));
		send_frame(b1, 1'b1);
		send_frame(b2, 1'b1);           // No read between
		wait_flag(FLAG_OVERRUN, 1'b1, FRAME_CYCLES, "overrun");
		bus_read(REG_UART, v, stalled);
		check("rx data after overrun", v, data_t'(b2));
		peek_reg(REG_FLAGS, v);
		check("overrun after read", v[FLAG_OVERRUN], 1'b0);
		// Low stop bit
		send_frame(b1, 1'b0);
		wait_flag(FLAG_FRAME_ERR, 1'b1, FRAME_CYCLES, "frame error");
		bus_read(REG_UART, v, stalled);
		check("rx data with frame error", v, data_t'(b1));
		peek_reg(REG_FLAGS, v);
		check("frame error after read", v[FLAG_FRAME_ERR], 1'b1);  // Belongs to the byte
		send_frame(CTRL_C_CODE, 1'b1);
		wait_flag(FLAG_CTRL_C, 1'b1, FRAME_CYCLES, "Ctrl-C");
		peek_reg(REG_FLAGS, v);
		check("frame error after good frame", v[FLAG_FRAME_ERR], 1'b0);
		bus_read(REG_UART, v, stalled);
		check("Ctrl-C data", v, data_t'(CTRL_C_CODE));
		peek_reg(REG_FLAGS, v);
		check("Ctrl-C after read", v[FLAG_CTRL_C], 1'b0);
		finish_test("rx errors");
	endtask

	// PWM --------------------
	task automatic pwm_duties();
		duty_t d;
		data_t f;
		logic stalled;
		int high;
		for (int k = 0; k < PWM_N; k++) begin
			d = duty_t'(rand_bits(PWM_BITS));
			// Align near count 0 so the clearing write misses it
			bus_write(REG_FLAGS, '0, stalled);
			wait_flag(FLAG_PWM_IRQ, 1'b1, PWM_PERIOD + 4, "PWM interrupt");
			bus_write(REG_FLAGS, data_t'(d), stalled);
			peek_reg(REG_FLAGS, f);
			check("PWM irq after FLAGS write", f[FLAG_PWM_IRQ], 1'b0);
			wait_flag(FLAG_PWM_IRQ, 1'b1, 2 * PWM_PERIOD, "PWM interrupt");
			high = 0;
			for (int i = 0; i < PWM_PERIOD; i++) begin
				high += pwm_out;        // One full period
				wait_cycles(1);
			end
			check("pwm_out high cycles", high, d);
		end
		finish_test("pwm");
	endtask

	// Registers --------------------
	task automatic register_effects();
		data_t v;
		logic stalled;
		logic got_irq;
		irq_vec_t got_vec;
		irq_src_t en;
		irq_src_t act;
		logic pwm_flag;     // Expected PWM interrupt
		logic gpo_val;
		send_frame(byte_t'(rand_bits(8)), 1'b1);   // Rx valid as a live source
		wait_flag(FLAG_RX_VALID, 1'b1, FRAME_CYCLES, "rx valid");
		// Start of a PWM period keeps the next count 0 far away
		bus_write(REG_FLAGS, '0, stalled);
		wait_flag(FLAG_PWM_IRQ, 1'b1, PWM_PERIOD + 4, "PWM interrupt");
		pwm_flag = 1'b1;
		for (int k = 0; k < IRQ_N; k++) begin
			en = irq_src_t'(rand_bits(3));
			bus_write(REG_IRQEN, data_t'(en), stalled);
			if (rand_bits(1) != 0) begin
				bus_write(REG_FLAGS, '0, stalled);  // Drop PWM irq
				pwm_flag = 1'b0;
			end
			addr = REG_FLAGS;
			#1;
			v = rdata;
			got_irq = irq;
			got_vec = irq_vec;
			act = en & {pwm_flag, 1'b1, 1'b1};     // Rx byte waiting and tx idle
			check("PWM irq flag", v[FLAG_PWM_IRQ], pwm_flag);
			check("irq", got_irq, |act);
			if (act != '0) check("irq_vec", got_vec, lowest_source(act));
			wait_cycles(1);
			bus_read(REG_IRQEN, v, stalled);
			check("IRQEN readback", v, data_t'(en));
		end
		bus_read(REG_UART, v, stalled);
		gpo_val = 1'(rand_bits(1));
		bus_write(REG_GPIO, data_t'(gpo_val), stalled);
		check("gpo", gpo, gpo_val);
		gpi = gpi_t'(rand_bits(7));
		bus_read(REG_GPIO, v, stalled);
		check("GPIO readback", v, data_t'({gpi, gpo_val}));
		bus_write(REG_SDTY, '0, stalled);
		peek_reg(REG_FLAGS, v);
		check("screen dirty after clear", v[FLAG_SDTY], 1'b0);
		bus_write(REG_UART, data_t'(rand_bits(8)), stalled);
		check("stall on tx write", stalled, 1'b0);
		peek_reg(REG_FLAGS, v);
		check("screen dirty after UART write", v[FLAG_SDTY], 1'b1);
		bus_write(REG_SDTY, '0, stalled);
		peek_reg(REG_FLAGS, v);
		check("screen dirty after SDTY write", v[FLAG_SDTY], 1'b0);
		peek_reg(3'd7, v);
		check("unmapped read", v, '0);
		finish_test("registers");
	endtask

	// Main sequence --------------------
	initial begin
		addr  = '0;
		wdata = '0;
		wr    = 1'b0;
		rd    = 1'b0;
		gpi   = '0;
		rxd   = IDLE_LEVEL;
		@(negedge reset);
		wait_cycles(1);
		transmit_frames();
		receive_frames();
		receive_errors();
		pwm_duties();
		register_effects();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/periph_pkg.sv
hdl/uart_pkg.sv
hdl/uart_if.sv
hdl/baud_counter.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/pwm_gen.sv
hdl/io_regs.sv
hdl/periph_top.sv
sim/tb_clock.sv
sim/periph_checker.sv
sim/tb_periph.sv
